// ==== dv/tb_tile_ctrl.sv ====
// tile controller testbench
// replays the test table against a beat order and edge padding model

`timescale 1ns/1ps

module tb_tile_ctrl;

  localparam int M          = 4;
  localparam int N          = 2;
  localparam int FIFO_DEPTH = 3;
  localparam int BIAS_W     = 8;
  localparam int BEATS      = M * M / N;

  typedef logic signed [N-1:0][BIAS_W-1:0] bias_vec_t;

  logic            clk_i, rst_ni;
  tile_pkg::ctrl_t ctrl_i;
  logic            inp_valid_i, weight_valid_i, bias_valid_i;
  logic            inp_ready_o, weight_ready_o, bias_ready_o;
  logic            oup_valid_i, oup_ready_i, requant_add_i, calc_en_o, busy_o;
  logic            first_inner_tile_o, last_inner_tile_o;
  bias_vec_t       inp_bias_i, inp_bias_pad_o;
  logic [N-1:0]    requant_add_o;
  tile_pkg::step_e step_o;
  tile_pkg::tcnt_t tile_x_o, tile_y_o, inner_tile_o;

  string           names[$];
  tile_pkg::ctrl_t cfgs[$];
  int              modes[$], beats[$];

  string           cur_name;
  tile_pkg::ctrl_t cur_cfg;
  tile_pkg::step_e m_step;
  int              m_beat, m_inner, m_x, m_y, m_tiles;
  int              inner_dim, x_wrap, total, col_limit;
  int              mode, pending, full_cycles, beats_seen, wd_cycles;
  bit              full_seen, start_req;
  logic [15:0]     lfsr = 16'd27;

  tile_ctrl_top #(.M(M), .N(N), .FIFO_DEPTH(FIFO_DEPTH), .BIAS_W(BIAS_W)) uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic valid_bit();
    if (mode == 2) begin
      return |rand_bits(2); // high three times in four
    end
    return 1'b1;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_pos(input tile_pkg::tile_pos_t exp, input tile_pkg::tile_pos_t act);
    if (exp !== act) begin
      fail_now($sformatf("FAILED %s position: expected %h, actual %h", cur_name, exp, act));
    end
  endtask

  task automatic check_bias(input bias_vec_t exp, input bias_vec_t act);
    if (exp !== act) begin
      fail_now($sformatf("FAILED %s bias lanes: expected %h, actual %h", cur_name, exp, act));
    end
  endtask

  task automatic check_mask(input logic [N-1:0] exp, input logic [N-1:0] act);
    if (exp !== act) begin
      fail_now($sformatf("FAILED %s requant lanes: expected %b, actual %b", cur_name, exp, act));
    end
  endtask

  task automatic check_step(input tile_pkg::step_e exp, input tile_pkg::step_e act);
    if (exp !== act) begin
      fail_now($sformatf("FAILED %s step: expected %s, actual %s",
                         cur_name, exp.name(), act.name()));
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (exp !== act) begin
      fail_now($sformatf("FAILED %s %s: expected %0d, actual %0d", cur_name, what, exp, act));
    end
  endtask

  task automatic set_geometry();
    inner_dim = cur_cfg.tile_e;
    case (m_step)
      tile_pkg::MatMul: begin
        x_wrap    = cur_cfg.tile_p;
        col_limit = cur_cfg.proj_space;
      end
      tile_pkg::F1: begin
        x_wrap    = cur_cfg.tile_f;
        col_limit = cur_cfg.ff_size;
      end
      default: begin // F2 contracts over the ff tiles
        inner_dim = cur_cfg.tile_f;
        x_wrap    = cur_cfg.tile_e;
        col_limit = cur_cfg.embed_size;
      end
    endcase
    total = cur_cfg.tile_s * x_wrap;
  endtask

  function automatic tile_pkg::tile_pos_t model_pos();
    tile_pkg::tile_pos_t p;
    p.step       = m_step;
    p.tile_x     = tile_pkg::tcnt_t'(m_x);
    p.tile_y     = tile_pkg::tcnt_t'(m_y);
    p.inner_tile = tile_pkg::tcnt_t'(m_inner);
    p.beat       = tile_pkg::beat_t'(m_beat);
    p.row_limit  = cur_cfg.seq_length;
    p.col_limit  = tile_pkg::dim_t'(col_limit);
    return p;
  endfunction

  function automatic tile_pkg::tile_pos_t dut_pos();
    tile_pkg::tile_pos_t p;
    p            = uut.pos; // beat and edge limits are internal only
    p.step       = step_o;
    p.tile_x     = tile_x_o;
    p.tile_y     = tile_y_o;
    p.inner_tile = inner_tile_o;
    return p;
  endfunction

  task automatic check_lanes();
    bias_vec_t    eb;
    logic [N-1:0] em;
    int           row, col0;
    row  = m_beat % M + m_y * M;
    col0 = m_beat / M * N + m_x * M;
    for (int i = 0; i < N; i++) begin
      eb[i] = '0;
      em[i] = 1'b0;
      if (row < int'(cur_cfg.seq_length) && col0 + i < col_limit) begin
        eb[i] = inp_bias_i[i];
        em[i] = requant_add_i;
      end
    end
    check_bias(eb, inp_bias_pad_o);
    check_mask(em, requant_add_o);
  endtask

  task automatic advance_model();
    m_beat++;
    if (m_beat == BEATS) begin
      m_beat = 0;
      m_inner++;
      if (m_inner == inner_dim) begin
        m_inner = 0;
        m_tiles++;
        m_x++;
        if (m_x == x_wrap) begin
          m_x = 0;
          m_y++;
        end
        if (m_tiles == total) begin
          m_tiles = 0;
          m_x     = 0;
          m_y     = 0;
          m_step  = (m_step == tile_pkg::F1) ? tile_pkg::F2 : tile_pkg::Idle;
          set_geometry();
        end
      end
    end
  endtask

  // one clock: drive on the falling edge, check 1 ns later
  task automatic tick(input bit drain);
    logic [31:0] r;
    bit          active, open_join, exp_fire, take, give;
    @(negedge clk_i);
    active         = m_step != tile_pkg::Idle;
    ctrl_i         = cur_cfg;
    ctrl_i.start   = start_req;
    inp_valid_i    = active && valid_bit();
    weight_valid_i = active && valid_bit();
    bias_valid_i   = active && valid_bit();
    r              = rand_bits(N * BIAS_W);
    inp_bias_i     = r[N*BIAS_W-1:0];
    requant_add_i  = rand_bits(1) != 0;
    oup_valid_i    = pending > 0; // only rows that were produced
    if (drain || mode == 0) begin
      oup_ready_i = 1'b1;
    end else if (mode == 1) begin
      oup_ready_i = full_cycles >= 4;
    end else begin
      oup_ready_i = rand_bits(1) != 0;
    end
    #1;
    open_join = pending < FIFO_DEPTH;
    exp_fire  = open_join && inp_valid_i && weight_valid_i && bias_valid_i;
    check_count("readies", {open_join && weight_valid_i, open_join && inp_valid_i,
                            open_join && weight_valid_i},
                {inp_ready_o, weight_ready_o, bias_ready_o});
    check_count("calc_en", exp_fire, calc_en_o);
    take = 1'b0;
    if (calc_en_o) begin
      check_step(m_step, step_o);
      check_pos(model_pos(), dut_pos());
      check_count("first inner flag", m_inner == 0, first_inner_tile_o);
      check_count("last inner flag", m_inner == inner_dim - 1, last_inner_tile_o);
      check_lanes();
      take = m_inner == inner_dim - 1;
      beats_seen++;
      advance_model();
    end
    give    = oup_valid_i && oup_ready_i;
    pending = pending + int'(take) - int'(give);
    if (pending == FIFO_DEPTH) begin
      full_cycles++;
      full_seen = 1'b1;
    end else begin
      full_cycles = 0;
    end
  endtask

  task automatic run_test(input int t);
    tile_pkg::step_e first;
    cur_name    = names[t];
    cur_cfg     = cfgs[t];
    mode        = modes[t];
    beats_seen  = 0;
    full_seen   = 1'b0;
    full_cycles = 0;
    first = (cur_cfg.layer == tile_pkg::Feedforward) ? tile_pkg::F1 : tile_pkg::MatMul;
    start_req = 1'b1;
    tick(1'b0);
    check_count("busy before start", 0, busy_o);
    start_req = 1'b0;
    m_step    = first;
    set_geometry();
    tick(1'b0);
    check_count("busy after start", 1, busy_o);
    check_step(first, step_o);
    while (m_step != tile_pkg::Idle) begin
      tick(1'b0);
    end
    tick(1'b1);
    check_step(tile_pkg::Idle, step_o);
    check_count("busy in first idle cycle", 1, busy_o);
    tick(1'b1);
    check_count("busy after idle", 0, busy_o);
    while (pending > 0) begin
      tick(1'b1);
    end
    check_count("beat count", beats[t], beats_seen);
    if (mode == 1) begin
      check_count("output fifo full reached", 1, int'(full_seen));
    end
  endtask

  task automatic read_tests();
    int              fd, n, layer, mode_v, beats_v, sum;
    int              d[4], tc[4];
    string           line, name;
    tile_pkg::ctrl_t c;
    sum = 0;
    fd  = $fopen("dv/tile_tests.txt", "r");
    if (fd == 0) begin
      fail_now("could not open the test table dv/tile_tests.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d", name, layer, d[0], d[1],
                    d[2], d[3], tc[0], tc[1], tc[2], tc[3], mode_v, beats_v);
        if (n != 12) begin
          fail_now($sformatf("malformed line in the test table: %s", line));
        end
        c            = '0;
        c.layer      = tile_pkg::layer_e'(layer);
        c.seq_length = tile_pkg::dim_t'(d[0]);
        c.embed_size = tile_pkg::dim_t'(d[1]);
        c.ff_size    = tile_pkg::dim_t'(d[2]);
        c.proj_space = tile_pkg::dim_t'(d[3]);
        c.tile_s     = tile_pkg::tcnt_t'(tc[0]);
        c.tile_e     = tile_pkg::tcnt_t'(tc[1]);
        c.tile_f     = tile_pkg::tcnt_t'(tc[2]);
        c.tile_p     = tile_pkg::tcnt_t'(tc[3]);
        names.push_back(name);
        cfgs.push_back(c);
        modes.push_back(mode_v);
        beats.push_back(beats_v);
        sum += beats_v;
      end
    end
    $fclose(fd);
    wd_cycles = sum * 8 + 200;
  endtask

  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk_i);
    fail_now($sformatf("timeout: run did not finish within %0d cycles, DUT appears hung",
                       wd_cycles));
  end

  initial begin
    rst_ni         = 1'b0;
    ctrl_i         = '0;
    cur_cfg        = '0;
    inp_valid_i    = 1'b0;
    weight_valid_i = 1'b0;
    bias_valid_i   = 1'b0;
    oup_valid_i    = 1'b0;
    oup_ready_i    = 1'b0;
    inp_bias_i     = '0;
    requant_add_i  = 1'b0;
    m_step         = tile_pkg::Idle;
    pending        = 0;
    cur_name       = "reset";
    read_tests();
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check_step(tile_pkg::Idle, step_o);
    check_count("busy", 0, busy_o);
    check_count("readies and calc_en", 0,
                {inp_ready_o, weight_ready_o, bias_ready_o, calc_en_o});
    foreach (names[t]) begin
      run_test(t);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== dv/tile_tests.txt ====
# name layer seq_length embed_size ff_size proj_space tile_s tile_e tile_f tile_p mode beats
# layer 0 linear or 1 feedforward; mode 0 free run, 1 output back-pressure, 2 random stalls
lin_even    0 8 8 8 8   2 2 2 2  0 64
lin_small   0 3 3 3 3   1 1 1 1  0 8
lin_pad     0 5 6 4 7   2 2 1 2  0 64
ff_even     1 4 8 8 4   1 2 2 1  0 64
ff_pad      1 6 5 7 4   2 2 2 1  0 128
lin_bp      0 8 4 4 12  2 1 1 3  1 48
ff_bp       1 4 4 8 4   1 1 2 1  1 32
lin_bp_pad  0 9 3 4 5   3 1 1 2  1 48
lin_rand    0 7 5 3 6   2 2 1 2  2 64
ff_rand     1 5 6 7 4   2 2 2 1  2 128

// ==== flist.f ====
src/tile_pkg.sv
src/operand_join.sv
src/tile_sequencer.sv
src/lane_pad.sv
src/tile_ctrl_top.sv
dv/tb_tile_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the tile controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_tile_ctrl
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_tile_ctrl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\*\* TEST PASSED \*\*\*$' "$LOG"; then
  echo "result: pass"
  exit 0
else
  echo "result: fail"
  exit 1
fi

// ==== src/lane_pad.sv ====
// edge padder
// zeroes the lanes of one beat that lie past the real matrix edge

`timescale 1ns/1ps

module lane_pad #(
  parameter int unsigned M = 64,
  parameter int unsigned N = 16,
  parameter type lane_t = logic
) (
  input  tile_pkg::tile_pos_t pos_i,
  input  lane_t [N-1:0]       lanes_i,
  output lane_t [N-1:0]       lanes_o
);

  // wide enough for tile index times tile side plus offsets
  localparam int unsigned PW = $bits(tile_pkg::tcnt_t) + $clog2(M) + 2;

  localparam lane_t ZERO = lane_t'(0);

  logic [PW-1:0] row;
  logic [PW-1:0] col0;
  logic          row_ok;

  // beats walk down the rows first, then step right by N columns
  assign row  = PW'(pos_i.beat % M) + PW'(pos_i.tile_y) * PW'(M);
  assign col0 = PW'(pos_i.beat / M) * PW'(N) + PW'(pos_i.tile_x) * PW'(M);

  assign row_ok = row < PW'(pos_i.row_limit);

  for (genvar i = 0; i < N; i++) begin : g_lane
    logic col_ok;

    assign col_ok     = (col0 + PW'(i)) < PW'(pos_i.col_limit);
    assign lanes_o[i] = (row_ok && col_ok) ? lanes_i[i] : ZERO;
  end

endmodule

// ==== src/operand_join.sv ====
// operand join with output credit gating
// fires one compute beat when input, weight and bias are all valid

`timescale 1ns/1ps

module operand_join #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic inp_valid_i,
  input  logic weight_valid_i,
  input  logic bias_valid_i,
  input  logic oup_valid_i,
  input  logic oup_ready_i,
  input  logic last_inner_i,
  output logic inp_ready_o,
  output logic weight_ready_o,
  output logic bias_ready_o,
  output logic fire_o
);

  localparam int unsigned CW = $clog2(FIFO_DEPTH + 1);

  logic [CW-1:0] credit_d, credit_q;
  logic          open_join;
  logic          take, give;

  assign open_join = credit_q < CW'(FIFO_DEPTH);

  // readies cross-coupled to the partner streams, as on the datapath side
  assign inp_ready_o    = open_join & weight_valid_i;
  assign weight_ready_o = open_join & inp_valid_i;
  assign bias_ready_o   = open_join & weight_valid_i;

  assign fire_o = open_join & inp_valid_i & weight_valid_i & bias_valid_i;

  assign take = fire_o & last_inner_i; // beat that will write an output row
  assign give = oup_valid_i & oup_ready_i;

  always_comb begin
    credit_d = credit_q;
    if (take && !give) begin
      credit_d = credit_q + 1'b1;
    end else if (give && !take) begin
      credit_d = credit_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= '0;
    end else begin
      credit_q <= credit_d;
    end
  end

  // output side must not pop more rows than were produced
  a_no_return_from_zero: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (credit_q == '0) |-> !(give && !take)
  );

endmodule

// ==== src/tile_ctrl_top.sv ====
// tile controller top
// operand join, tile sequencer and edge padding for bias and requant add

`timescale 1ns/1ps

module tile_ctrl_top #(
  parameter int unsigned M          = 64,
  parameter int unsigned N          = 16,
  parameter int unsigned FIFO_DEPTH = 4,
  parameter int unsigned BIAS_W     = 24
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  tile_pkg::ctrl_t               ctrl_i,
  input  logic                          inp_valid_i,
  output logic                          inp_ready_o,
  input  logic                          weight_valid_i,
  output logic                          weight_ready_o,
  input  logic                          bias_valid_i,
  output logic                          bias_ready_o,
  input  logic                          oup_valid_i,
  input  logic                          oup_ready_i,
  input  logic signed [N-1:0][BIAS_W-1:0] inp_bias_i,
  input  logic                          requant_add_i,
  output logic                          calc_en_o,
  output tile_pkg::step_e               step_o,
  output tile_pkg::tcnt_t               tile_x_o,
  output tile_pkg::tcnt_t               tile_y_o,
  output tile_pkg::tcnt_t               inner_tile_o,
  output logic                          first_inner_tile_o,
  output logic                          last_inner_tile_o,
  output logic signed [N-1:0][BIAS_W-1:0] inp_bias_pad_o,
  output logic [N-1:0]                  requant_add_o,
  output logic                          busy_o
);

  tile_pkg::tile_pos_t pos;
  logic                fire;
  logic                last_inner;
  logic [N-1:0]        requant_lanes;

  operand_join #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_join (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .inp_valid_i    (inp_valid_i),
    .weight_valid_i (weight_valid_i),
    .bias_valid_i   (bias_valid_i),
    .oup_valid_i    (oup_valid_i),
    .oup_ready_i    (oup_ready_i),
    .last_inner_i   (last_inner),
    .inp_ready_o    (inp_ready_o),
    .weight_ready_o (weight_ready_o),
    .bias_ready_o   (bias_ready_o),
    .fire_o         (fire)
  );

  tile_sequencer #(
    .M (M),
    .N (N)
  ) u_seq (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ctrl_i        (ctrl_i),
    .fire_i        (fire),
    .pos_o         (pos),
    .first_inner_o (first_inner_tile_o),
    .last_inner_o  (last_inner),
    .busy_o        (busy_o)
  );

  lane_pad #(
    .M      (M),
    .N      (N),
    .lane_t (logic signed [BIAS_W-1:0])
  ) u_pad_bias (
    .pos_i   (pos),
    .lanes_i (inp_bias_i),
    .lanes_o (inp_bias_pad_o)
  );

  assign requant_lanes = {N{requant_add_i}}; // one flag for the whole beat

  lane_pad #(
    .M      (M),
    .N      (N),
    .lane_t (logic)
  ) u_pad_requant (
    .pos_i   (pos),
    .lanes_i (requant_lanes),
    .lanes_o (requant_add_o)
  );

  assign calc_en_o         = fire;
  assign last_inner_tile_o = last_inner;
  assign step_o            = pos.step;
  assign tile_x_o          = pos.tile_x;
  assign tile_y_o          = pos.tile_y;
  assign inner_tile_o      = pos.inner_tile;

endmodule

// ==== src/tile_pkg.sv ====
// tile sequencer shared types
// layer and step encodings, configuration word and beat position

package tile_pkg;

  // layer kinds still handled by the sequencer
  typedef enum logic [1:0] {
    Linear      = 2'd0,
    Feedforward = 2'd1
  } layer_e;

  typedef enum logic [1:0] {
    Idle   = 2'd0,
    MatMul = 2'd1,
    F1     = 2'd2, // first feedforward matmul
    F2     = 2'd3
  } step_e;

  typedef logic [9:0]  dim_t;  // matrix dimension in elements
  typedef logic [7:0]  tcnt_t; // tile count or tile index
  typedef logic [11:0] beat_t; // beat index inside one tile

  // layer configuration, sampled on start and held while busy
  typedef struct packed {
    logic   start;
    layer_e layer;
    dim_t   seq_length;
    dim_t   embed_size;
    dim_t   ff_size;
    dim_t   proj_space;
    tcnt_t  tile_s;
    tcnt_t  tile_e;
    tcnt_t  tile_f;
    tcnt_t  tile_p;
  } ctrl_t;

  // where the current beat sits in the output matrix
  typedef struct packed {
    step_e step;
    tcnt_t tile_x;
    tcnt_t tile_y;
    tcnt_t inner_tile;
    beat_t beat;
    dim_t  row_limit; // real rows of this step
    dim_t  col_limit; // real columns of this step
  } tile_pos_t;

endpackage

// ==== src/tile_sequencer.sv ====
// tile sequencer
// steps through beats, inner tiles and output tiles of linear and ff layers

`timescale 1ns/1ps

module tile_sequencer #(
  parameter int unsigned M = 64,
  parameter int unsigned N = 16
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  tile_pkg::ctrl_t   ctrl_i,
  input  logic              fire_i,
  output tile_pkg::tile_pos_t pos_o,
  output logic              first_inner_o,
  output logic              last_inner_o,
  output logic              busy_o
);

  localparam int unsigned BEATS = M * M / N;
  localparam int unsigned OW    = 2 * $bits(tile_pkg::tcnt_t);

  tile_pkg::step_e step_d, step_q, start_step;
  tile_pkg::beat_t beat_d, beat_q;
  tile_pkg::tcnt_t inner_d, inner_q;
  tile_pkg::tcnt_t tile_x_d, tile_x_q;
  tile_pkg::tcnt_t tile_y_d, tile_y_q;
  logic [OW-1:0]   tile_d, tile_q; // finished output tiles in this step
  logic            busy_d, busy_q;

  // per-step geometry
  tile_pkg::tcnt_t inner_dim, x_wrap;
  tile_pkg::tcnt_t inner_last, x_last;
  logic [OW-1:0]   total, total_last;
  tile_pkg::dim_t  col_limit;

  always_comb begin
    unique case (step_q)
      tile_pkg::MatMul: begin
        inner_dim = ctrl_i.tile_e;
        x_wrap    = ctrl_i.tile_p;
        total     = ctrl_i.tile_s * ctrl_i.tile_p;
        col_limit = ctrl_i.proj_space;
      end
      tile_pkg::F1: begin
        inner_dim = ctrl_i.tile_e;
        x_wrap    = ctrl_i.tile_f;
        total     = ctrl_i.tile_s * ctrl_i.tile_f;
        col_limit = ctrl_i.ff_size;
      end
      tile_pkg::F2: begin
        inner_dim = ctrl_i.tile_f; // contracts over the ff dimension
        x_wrap    = ctrl_i.tile_e;
        total     = ctrl_i.tile_s * ctrl_i.tile_e;
        col_limit = ctrl_i.embed_size;
      end
      default: begin
        inner_dim = '0;
        x_wrap    = '0;
        total     = '0;
        col_limit = '0;
      end
    endcase
  end

  assign inner_last = inner_dim - 1'b1;
  assign x_last     = x_wrap - 1'b1;
  assign total_last = total - 1'b1;

  always_comb begin
    unique case (ctrl_i.layer)
      tile_pkg::Linear:      start_step = tile_pkg::MatMul;
      tile_pkg::Feedforward: start_step = tile_pkg::F1;
      default:               start_step = tile_pkg::Idle;
    endcase
    if (!ctrl_i.start) begin
      start_step = tile_pkg::Idle;
    end
  end

  always_comb begin
    step_d   = step_q;
    beat_d   = beat_q;
    inner_d  = inner_q;
    tile_x_d = tile_x_q;
    tile_y_d = tile_y_q;
    tile_d   = tile_q;
    busy_d   = (step_q != tile_pkg::Idle) || (start_step != tile_pkg::Idle);

    if (step_q == tile_pkg::Idle) begin
      step_d = start_step; // counters are already zero here
    end else if (fire_i) begin
      beat_d = beat_q + 1'b1;
      if (beat_q == tile_pkg::beat_t'(BEATS - 1)) begin // end of tile
        beat_d  = '0;
        inner_d = inner_q + 1'b1;
        if (inner_q == inner_last) begin
          inner_d = '0;
          tile_d  = tile_q + 1'b1;
          if (tile_x_q == x_last) begin
            tile_x_d = '0;
            tile_y_d = tile_y_q + 1'b1;
          end else begin
            tile_x_d = tile_x_q + 1'b1;
          end
          if (tile_q == total_last) begin // end of step
            tile_d   = '0;
            tile_x_d = '0;
            tile_y_d = '0;
            step_d   = (step_q == tile_pkg::F1) ? tile_pkg::F2 : tile_pkg::Idle;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_q   <= tile_pkg::Idle;
      beat_q   <= '0;
      inner_q  <= '0;
      tile_x_q <= '0;
      tile_y_q <= '0;
      tile_q   <= '0;
      busy_q   <= 1'b0;
    end else begin
      step_q   <= step_d;
      beat_q   <= beat_d;
      inner_q  <= inner_d;
      tile_x_q <= tile_x_d;
      tile_y_q <= tile_y_d;
      tile_q   <= tile_d;
      busy_q   <= busy_d;
    end
  end

  assign pos_o.step       = step_q;
  assign pos_o.tile_x     = tile_x_q;
  assign pos_o.tile_y     = tile_y_q;
  assign pos_o.inner_tile = inner_q;
  assign pos_o.beat       = beat_q;
  assign pos_o.row_limit  = ctrl_i.seq_length; // rows are the sequence in every step
  assign pos_o.col_limit  = col_limit;

  assign first_inner_o = inner_q == '0;
  assign last_inner_o  = (step_q != tile_pkg::Idle) && (inner_q == inner_last);
  assign busy_o        = busy_q;

  // inner index wraps at the step's contraction depth
  a_inner_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (step_q != tile_pkg::Idle) |-> (inner_q < inner_dim)
  );

endmodule
